//--- common/rv_consts.svh
// width, register count and data memory depth constants for the core
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// integer register and datapath width
`define RV_XLEN 32

// architectural integer registers x0 to x31
`define RV_NUM_REGS 32

// data memory depth in words
// addresses wrap at this depth
`define RV_DMEM_WORDS 256

`endif

//--- common/rv_isa_pkg.sv
// instruction set encodings for the major opcodes and the branch funct3 field
`default_nettype none

package rv_isa_pkg;

	// RV32I major opcodes in instruction bits 6 to 0
	typedef enum logic [6:0] {
		// register register arithmetic
		OPC_OP     = 7'b0110011,
		// register immediate arithmetic
		OPC_OP_IMM = 7'b0010011,
		// word load
		OPC_LOAD   = 7'b0000011,
		// word store
		OPC_STORE  = 7'b0100011,
		// conditional branches
		OPC_BRANCH = 7'b1100011,
		// jump and link relative to pc
		OPC_JAL    = 7'b1101111,
		// jump and link relative to rs1
		OPC_JALR   = 7'b1100111,
		// load upper immediate
		OPC_LUI    = 7'b0110111,
		// add upper immediate to pc
		OPC_AUIPC  = 7'b0010111
	} opcode_t;

	// funct3 values of the conditional branches
	typedef enum logic [2:0] {
		BR_BEQ  = 3'b000,
		BR_BNE  = 3'b001,
		// signed compares
		BR_BLT  = 3'b100,
		BR_BGE  = 3'b101,
		// unsigned compares
		BR_BLTU = 3'b110,
		BR_BGEU = 3'b111
	} branch_funct3_t;

endpackage

`default_nettype wire

//--- common/rv_ctrl_pkg.sv
// datapath control types for the ALU, operand muxes and writeback select
`default_nettype none

package rv_ctrl_pkg;

	// ALU operation, numbered like the OP funct3 field
	typedef enum logic [2:0] {
		// add, or subtract when sign is set
		ALU_ADD  = 3'b000,
		ALU_SLL  = 3'b001,
		ALU_SLT  = 3'b010,
		ALU_SLTU = 3'b011,
		ALU_XOR  = 3'b100,
		// logical shift, or arithmetic when sign is set
		ALU_SRL  = 3'b101,
		ALU_OR   = 3'b110,
		ALU_AND  = 3'b111
	} alu_op_t;

	// first ALU operand source
	typedef enum logic [1:0] {
		OP1_RS1  = 2'd0,
		OP1_PC   = 2'd1,
		OP1_ZERO = 2'd2
	} op1_src_t;

	// second ALU operand source
	typedef enum logic {
		OP2_RS2 = 1'b0,
		OP2_IMM = 1'b1
	} op2_src_t;

	// register file writeback source
	typedef enum logic [1:0] {
		RD_ALU  = 2'd0,
		RD_MEM  = 2'd1,
		// pc + 4 for jumps
		RD_LINK = 2'd2
	} rd_sel_t;

endpackage

`default_nettype wire

//--- decode/immediate_decode.sv
// immediate, branch, ALU control and top level instruction decoders
`default_nettype none
`include "rv_consts.svh"

module immediate_decode import rv_isa_pkg::*; (
	input logic [31:0] instruction,
	output logic [`RV_XLEN-1:0] immediate
);

	opcode_t opcode;

	assign opcode = opcode_t'(instruction[6:0]);

	// bit 31 is the sign bit of every immediate format
	always_comb
		case (opcode)
			// I type
			OPC_OP_IMM, OPC_LOAD, OPC_JALR:
				immediate = {{(`RV_XLEN-12){instruction[31]}}, instruction[31:20]};
			// S type, split around rd
			OPC_STORE:
				immediate = {{(`RV_XLEN-12){instruction[31]}},
					instruction[31:25], instruction[11:7]};
			// B type, offset in halfwords
			OPC_BRANCH:
				immediate = {{(`RV_XLEN-13){instruction[31]}},
					instruction[31], instruction[7],
					instruction[30:25], instruction[11:8], 1'b0};
			// J type, offset in halfwords
			OPC_JAL:
				immediate = {{(`RV_XLEN-21){instruction[31]}},
					instruction[31], instruction[19:12],
					instruction[20], instruction[30:21], 1'b0};
			// U type, upper 20 bits
			OPC_LUI, OPC_AUIPC:
				immediate = {instruction[31:12], 12'b0};
			// no immediate for OP or unknown opcodes
			default:
				immediate = '0;
		endcase

endmodule

module branch_decode import rv_isa_pkg::*; (
	input opcode_t opcode,
	input logic [2:0] funct3,
	output logic jump,
	output logic branch,
	output logic branch_if_zero,
	output logic branch_base
);

	// JAL and JALR always redirect
	assign jump = (opcode == OPC_JAL) || (opcode == OPC_JALR);
	assign branch = (opcode == OPC_BRANCH);

	// BEQ takes on an equal subtract, BGE and BGEU on a clear less-than
	always_comb
		case (branch_funct3_t'(funct3))
			BR_BEQ, BR_BGE, BR_BGEU:
				branch_if_zero = 1'b1;
			default:
				branch_if_zero = 1'b0;
		endcase

	// only JALR targets rs1
	assign branch_base = (opcode == OPC_JALR);

endmodule

module alu_decode import rv_isa_pkg::*, rv_ctrl_pkg::*; (
	input logic [31:0] instruction,
	output alu_op_t alu_op,
	output logic sign,
	output op1_src_t op1_src,
	output op2_src_t op2_src
);

	opcode_t opcode;
	logic [2:0] funct3;

	assign opcode = opcode_t'(instruction[6:0]);
	assign funct3 = instruction[14:12];

	always_comb
	begin
		alu_op = ALU_ADD;
		sign = 1'b0;
		if (opcode == OPC_BRANCH)
		begin
			case (branch_funct3_t'(funct3))
				// equality through the subtract zero flag
				BR_BEQ, BR_BNE:
				begin
					alu_op = ALU_ADD;
					sign = 1'b1;
				end
				BR_BLT, BR_BGE:
					alu_op = ALU_SLT;
				BR_BLTU, BR_BGEU:
					alu_op = ALU_SLTU;
				default:
					alu_op = ALU_ADD;
			endcase
		end
		else if (opcode == OPC_OP)
		begin
			alu_op = alu_op_t'(funct3);
			// SUB and SRA
			sign = instruction[30];
		end
		else if (opcode == OPC_OP_IMM)
		begin
			alu_op = alu_op_t'(funct3);
			// bit 30 is only a control bit for the shifts, SRAI
			if (funct3 == ALU_SRL || funct3 == ALU_SLL)
				sign = instruction[30];
		end
		// upper immediates and address generation stay on the adder
	end

	// pc for AUIPC, zero so LUI passes the immediate through
	always_comb
		case (opcode)
			OPC_LUI:
				op1_src = OP1_ZERO;
			OPC_AUIPC:
				op1_src = OP1_PC;
			default:
				op1_src = OP1_RS1;
		endcase

	always_comb
		case (opcode)
			OPC_OP_IMM, OPC_LOAD, OPC_STORE, OPC_JALR, OPC_LUI, OPC_AUIPC:
				op2_src = OP2_IMM;
			// OP and branch compares use rs2
			default:
				op2_src = OP2_RS2;
		endcase

endmodule

module instruction_decode import rv_isa_pkg::*, rv_ctrl_pkg::*; (
	input logic [31:0] instruction,
	output logic [4:0] rs1,
	output logic [4:0] rs2,
	output logic [4:0] rd,
	output logic [`RV_XLEN-1:0] immediate,
	output op1_src_t op1_src,
	output op2_src_t op2_src,
	output rd_sel_t rd_select,
	output alu_op_t alu_op,
	output logic sign,
	output logic branch,
	output logic branch_if_zero,
	output logic jump,
	output logic branch_base,
	output logic rf_write_en,
	output logic mem_write_en
);

	opcode_t opcode;
	logic [2:0] funct3;

	assign opcode = opcode_t'(instruction[6:0]);
	assign funct3 = instruction[14:12];

	// register fields sit at fixed positions in every format
	assign rs1 = instruction[19:15];
	assign rs2 = instruction[24:20];
	assign rd = instruction[11:7];

	branch_decode u_branch_decode (
		.opcode(opcode),
		.funct3(funct3),
		.jump(jump),
		.branch(branch),
		.branch_if_zero(branch_if_zero),
		.branch_base(branch_base)
	);

	immediate_decode u_immediate_decode (
		.instruction(instruction),
		.immediate(immediate)
	);

	alu_decode u_alu_decode (
		.instruction(instruction),
		.alu_op(alu_op),
		.sign(sign),
		.op1_src(op1_src),
		.op2_src(op2_src)
	);

	// writeback source, don't care when rd is not written
	always_comb
		case (opcode)
			OPC_LOAD:
				rd_select = RD_MEM;
			OPC_JAL, OPC_JALR:
				rd_select = RD_LINK;
			default:
				rd_select = RD_ALU;
		endcase

	// stores, branches and unknown opcodes leave the register file alone
	always_comb
		case (opcode)
			OPC_OP, OPC_OP_IMM, OPC_LOAD, OPC_JAL, OPC_JALR, OPC_LUI, OPC_AUIPC:
				rf_write_en = 1'b1;
			default:
				rf_write_en = 1'b0;
		endcase

	assign mem_write_en = (opcode == OPC_STORE);

	// an instruction writes at most one of the two state arrays
	always_comb
	begin
		assert final (!(rf_write_en && mem_write_en))
		else $error("decode enabled both register and memory write");
	end

endmodule

`default_nettype wire

//--- rtl/reg_file.sv
// integer register file with two read ports, one write port and x0 tied to zero
`default_nettype none
`include "rv_consts.svh"

module reg_file (
	input logic clk,
	input logic rst,
	input logic [$clog2(`RV_NUM_REGS)-1:0] rs1,
	input logic [$clog2(`RV_NUM_REGS)-1:0] rs2,
	output logic [`RV_XLEN-1:0] rs1_data,
	output logic [`RV_XLEN-1:0] rs2_data,
	input logic [$clog2(`RV_NUM_REGS)-1:0] rd,
	input logic [`RV_XLEN-1:0] rd_data,
	input logic we
);

	logic [`RV_XLEN-1:0] regs [`RV_NUM_REGS];

	// reads are combinational so an instruction sees the state before its own write
	assign rs1_data = regs[rs1];
	assign rs2_data = regs[rs2];

	// x0 is cleared by reset and never written after
	always_ff @(posedge clk)
		if (rst)
		begin
			for (int i = 0; i < `RV_NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (we && rd != '0)
		begin
			regs[rd] <= rd_data;
		end

	// x0 must read back as zero on both ports for the whole run
	assert property (@(posedge clk) disable iff (rst)
		(rs1 == '0) |-> (rs1_data == '0))
	else $error("x0 read nonzero on port 1");

	assert property (@(posedge clk) disable iff (rst)
		(rs2 == '0) |-> (rs2_data == '0))
	else $error("x0 read nonzero on port 2");

endmodule

`default_nettype wire

//--- rtl/alu.sv
// integer ALU with the eight RV32I operations and a zero flag
`default_nettype none
`include "rv_consts.svh"

module alu import rv_ctrl_pkg::*; (
	input logic [`RV_XLEN-1:0] op_a,
	input logic [`RV_XLEN-1:0] op_b,
	input alu_op_t alu_op,
	input logic sign,
	output logic [`RV_XLEN-1:0] result,
	output logic zero
);

	localparam int SHAMT_BITS = $clog2(`RV_XLEN);

	logic [SHAMT_BITS-1:0] shamt;

	// shifts only look at the low bits of the second operand
	assign shamt = op_b[SHAMT_BITS-1:0];

	always_comb
		case (alu_op)
			ALU_ADD:
				if (sign)
					result = op_a - op_b;
				else
					result = op_a + op_b;
			ALU_SLL:
				result = op_a << shamt;
			ALU_SLT:
				result = {{(`RV_XLEN-1){1'b0}}, ($signed(op_a) < $signed(op_b))};
			ALU_SLTU:
				result = {{(`RV_XLEN-1){1'b0}}, (op_a < op_b)};
			ALU_XOR:
				result = op_a ^ op_b;
			ALU_SRL:
				// arithmetic shift fills with the sign bit of op_a
				if (sign)
					result = $signed(op_a) >>> shamt;
				else
					result = op_a >> shamt;
			ALU_OR:
				result = op_a | op_b;
			ALU_AND:
				result = op_a & op_b;
			default:
				result = '0;
		endcase

	// equality for BEQ and BNE and the compare result for the other branches
	assign zero = (result == '0);

endmodule

`default_nettype wire

//--- rtl/data_mem.sv
// word wide data RAM with combinational read and synchronous write
`default_nettype none
`include "rv_consts.svh"

module data_mem (
	input logic clk,
	input logic [`RV_XLEN-1:0] addr,
	input logic [`RV_XLEN-1:0] wdata,
	input logic we,
	output logic [`RV_XLEN-1:0] rdata
);

	localparam int IDX_BITS = $clog2(`RV_DMEM_WORDS);

	logic [`RV_XLEN-1:0] mem [`RV_DMEM_WORDS];
	logic [IDX_BITS-1:0] word_idx;

	// byte address to word index
	// upper address bits are dropped so accesses wrap at the memory depth
	assign word_idx = addr[IDX_BITS+1:2];

	// load data is ready in the same cycle as the address
	assign rdata = mem[word_idx];

	// every store is a full word
	always_ff @(posedge clk)
		if (we)
		begin
			mem[word_idx] <= wdata;
		end

	// the ALU computed address must be word aligned for a store
	assert property (@(posedge clk) we |-> (addr[1:0] == 2'b00))
	else $error("misaligned store to address %h", addr);

endmodule

`default_nettype wire

//--- rtl/rv_core.sv
// single cycle RV32I core with pc, operand muxes, branch resolution and commit trace
`default_nettype none
`include "rv_consts.svh"

module rv_core import rv_ctrl_pkg::*; (
	input logic clk,
	input logic rst,
	input logic instr_valid,
	input logic [31:0] instruction,
	output logic [`RV_XLEN-1:0] pc,
	output logic retire_valid,
	output logic [`RV_XLEN-1:0] retire_pc,
	output logic [`RV_XLEN-1:0] retire_next_pc,
	output logic retire_rd_we,
	output logic [4:0] retire_rd,
	output logic [`RV_XLEN-1:0] retire_rd_data
);

	logic [4:0] rs1;
	logic [4:0] rs2;
	logic [4:0] rd;
	logic [`RV_XLEN-1:0] immediate;
	op1_src_t op1_src;
	op2_src_t op2_src;
	rd_sel_t rd_select;
	alu_op_t alu_op;
	logic sign;
	logic branch;
	logic branch_if_zero;
	logic jump;
	logic branch_base;
	logic rf_write_en;
	logic mem_write_en;

	logic [`RV_XLEN-1:0] rs1_data;
	logic [`RV_XLEN-1:0] rs2_data;
	logic [`RV_XLEN-1:0] op_a;
	logic [`RV_XLEN-1:0] op_b;
	logic [`RV_XLEN-1:0] alu_result;
	logic alu_zero;
	logic [`RV_XLEN-1:0] load_data;
	logic [`RV_XLEN-1:0] wb_data;
	logic [`RV_XLEN-1:0] pc_plus_four;
	logic [`RV_XLEN-1:0] target;
	logic [`RV_XLEN-1:0] next_pc;
	logic taken;
	logic rf_we;
	logic mem_we;

	instruction_decode u_decode (
		.instruction(instruction),
		.rs1(rs1),
		.rs2(rs2),
		.rd(rd),
		.immediate(immediate),
		.op1_src(op1_src),
		.op2_src(op2_src),
		.rd_select(rd_select),
		.alu_op(alu_op),
		.sign(sign),
		.branch(branch),
		.branch_if_zero(branch_if_zero),
		.jump(jump),
		.branch_base(branch_base),
		.rf_write_en(rf_write_en),
		.mem_write_en(mem_write_en)
	);

	// state only changes on a strobed instruction
	assign rf_we = rf_write_en & instr_valid;
	assign mem_we = mem_write_en & instr_valid;

	reg_file u_reg_file (
		.clk(clk),
		.rst(rst),
		.rs1(rs1),
		.rs2(rs2),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.rd(rd),
		.rd_data(wb_data),
		.we(rf_we)
	);

	// first operand
	always_comb
		case (op1_src)
			OP1_PC:
				op_a = pc;
			OP1_ZERO:
				op_a = '0;
			default:
				op_a = rs1_data;
		endcase

	assign op_b = (op2_src == OP2_IMM) ? immediate : rs2_data;

	alu u_alu (
		.op_a(op_a),
		.op_b(op_b),
		.alu_op(alu_op),
		.sign(sign),
		.result(alu_result),
		.zero(alu_zero)
	);

	// store data always comes from rs2
	data_mem u_dmem (
		.clk(clk),
		.addr(alu_result),
		.wdata(rs2_data),
		.we(mem_we),
		.rdata(load_data)
	);

	assign pc_plus_four = pc + `RV_XLEN'd4;

	// a branch takes when the zero flag matches the wanted polarity
	assign taken = jump | (branch & (branch_if_zero == alu_zero));

	// JALR adds to rs1 and drops bit 0, everything else is pc relative
	always_comb
		if (branch_base)
			target = (rs1_data + immediate) & ~`RV_XLEN'd1;
		else
			target = pc + immediate;

	assign next_pc = taken ? target : pc_plus_four;

	always_comb
		case (rd_select)
			RD_MEM:
				wb_data = load_data;
			RD_LINK:
				wb_data = pc_plus_four;
			default:
				wb_data = alu_result;
		endcase

	always_ff @(posedge clk)
		if (rst)
			pc <= '0;
		else if (instr_valid)
			pc <= next_pc;

	// trace strobe and write flag, low between retires
	always_ff @(posedge clk)
		if (rst)
		begin
			retire_valid <= 1'b0;
			retire_rd_we <= 1'b0;
		end
		else
		begin
			retire_valid <= instr_valid;
			retire_rd_we <= rf_we;
		end

	// trace payload, held until the next retire
	always_ff @(posedge clk)
		if (instr_valid)
		begin
			retire_pc <= pc;
			retire_next_pc <= next_pc;
			retire_rd <= rd;
			retire_rd_data <= wb_data;
		end

	// each retire pairs with a strobe one cycle earlier
	assert property (@(posedge clk) disable iff (rst) retire_valid |-> $past(instr_valid))
	else $error("retire without a preceding instruction strobe");

endmodule

`default_nettype wire

//--- dv/rv_core_tb.sv
// testbench for rv_core with clock, reset, instruction table and retire checks
`default_nettype none
`include "rv_consts.svh"

module rv_core_tb import rv_isa_pkg::*;;

	localparam int CLK_PERIOD = 20;
	localparam int RETIRE_TIMEOUT = 10;
	localparam int RUN_LIMIT = 4000;
	// byte address used by the store and load pair
	localparam int STORE_ADDR = 'h48;

	// funct3 codes of OP, OP_IMM and word memory access
	localparam logic [2:0] F3_ADD = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SR = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;
	localparam logic [2:0] F3_WORD = 3'b010;

	// one instruction with its expected commit trace
	typedef struct {
		logic [31:0] instr;
		logic [`RV_XLEN-1:0] pc;
		logic [`RV_XLEN-1:0] next_pc;
		logic rd_we;
		logic [4:0] rd;
		logic [`RV_XLEN-1:0] rd_data;
	} entry_t;

	logic clk;
	logic rst;
	logic instr_valid;
	logic [31:0] instruction;
	logic [`RV_XLEN-1:0] pc;
	logic retire_valid;
	logic [`RV_XLEN-1:0] retire_pc;
	logic [`RV_XLEN-1:0] retire_next_pc;
	logic retire_rd_we;
	logic [4:0] retire_rd;
	logic [`RV_XLEN-1:0] retire_rd_data;

	entry_t stim [$];

	rv_core u_dut (
		.clk(clk),
		.rst(rst),
		.instr_valid(instr_valid),
		.instruction(instruction),
		.pc(pc),
		.retire_valid(retire_valid),
		.retire_pc(retire_pc),
		.retire_next_pc(retire_next_pc),
		.retire_rd_we(retire_rd_we),
		.retire_rd(retire_rd),
		.retire_rd_data(retire_rd_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("Simulation failed");
		$fatal(1);
	endtask

	task automatic check_value(input string what, input logic [`RV_XLEN-1:0] got,
		input logic [`RV_XLEN-1:0] exp);
		assert (got === exp)
		else fail_run($sformatf("MISMATCH at time %0t: %s is %h, expected %h",
			$time, what, got, exp));
	endtask

	// RV32I instruction encoders for each format
	function automatic logic [31:0] encode_r(input logic [6:0] funct7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd);
		return {funct7, rs2, rs1, funct3, rd, OPC_OP};
	endfunction

	function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] funct3, input logic [4:0] rd, input opcode_t opc);
		return {imm, rs1, funct3, rd, opc};
	endfunction

	function automatic logic [31:0] encode_s(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, F3_WORD, imm[4:0], OPC_STORE};
	endfunction

	// offset in bytes with bit 0 dropped by the format
	function automatic logic [31:0] encode_b(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input branch_funct3_t f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] encode_u(input logic [19:0] imm, input logic [4:0] rd,
		input opcode_t opc);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] encode_j(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OPC_JAL};
	endfunction

	task automatic add_entry(input logic [31:0] instr, input logic [`RV_XLEN-1:0] epc,
		input logic [`RV_XLEN-1:0] enext, input logic ewe, input logic [4:0] erd,
		input logic [`RV_XLEN-1:0] edata);
		entry_t e;
		e.instr = instr;
		e.pc = epc;
		e.next_pc = enext;
		e.rd_we = ewe;
		e.rd = erd;
		e.rd_data = edata;
		stim.push_back(e);
	endtask

	// expected values worked out by hand from the RV32I rules
	// x1 = 5 and x2 = -3 feed most of them
	task automatic build_table();
		add_entry(encode_i(12'd5, 5'd0, F3_ADD, 5'd1, OPC_OP_IMM), 32'h00, 32'h04, 1'b1, 5'd1,
			32'h5);
		add_entry(encode_i(12'hffd, 5'd0, F3_ADD, 5'd2, OPC_OP_IMM), 32'h04, 32'h08, 1'b1, 5'd2,
			32'hffff_fffd);
		add_entry(encode_r(7'h00, 5'd2, 5'd1, F3_ADD, 5'd3), 32'h08, 32'h0c, 1'b1, 5'd3, 32'h2);
		add_entry(encode_r(7'h20, 5'd2, 5'd1, F3_ADD, 5'd4), 32'h0c, 32'h10, 1'b1, 5'd4, 32'h8);
		// -3 is below 5 signed but not unsigned
		add_entry(encode_r(7'h00, 5'd1, 5'd2, F3_SLT, 5'd5), 32'h10, 32'h14, 1'b1, 5'd5, 32'h1);
		add_entry(encode_r(7'h00, 5'd1, 5'd2, F3_SLTU, 5'd6), 32'h14, 32'h18, 1'b1, 5'd6, 32'h0);
		add_entry(encode_r(7'h00, 5'd2, 5'd1, F3_XOR, 5'd7), 32'h18, 32'h1c, 1'b1, 5'd7,
			32'hffff_fff8);
		add_entry(encode_r(7'h00, 5'd2, 5'd1, F3_OR, 5'd8), 32'h1c, 32'h20, 1'b1, 5'd8,
			32'hffff_fffd);
		add_entry(encode_r(7'h00, 5'd2, 5'd1, F3_AND, 5'd9), 32'h20, 32'h24, 1'b1, 5'd9, 32'h5);
		add_entry(encode_r(7'h00, 5'd1, 5'd1, F3_SLL, 5'd10), 32'h24, 32'h28, 1'b1, 5'd10,
			32'ha0);
		add_entry(encode_r(7'h00, 5'd1, 5'd2, F3_SR, 5'd11), 32'h28, 32'h2c, 1'b1, 5'd11,
			32'h07ff_ffff);
		add_entry(encode_r(7'h20, 5'd1, 5'd2, F3_SR, 5'd12), 32'h2c, 32'h30, 1'b1, 5'd12,
			32'hffff_ffff);
		// SRAI by one with funct7 in the upper immediate bits
		add_entry(encode_i(12'h401, 5'd2, F3_SR, 5'd13, OPC_OP_IMM), 32'h30, 32'h34, 1'b1, 5'd13,
			32'hffff_fffe);
		add_entry(encode_u(20'h12345, 5'd14, OPC_LUI), 32'h34, 32'h38, 1'b1, 5'd14,
			32'h1234_5000);
		add_entry(encode_u(20'h00001, 5'd15, OPC_AUIPC), 32'h38, 32'h3c, 1'b1, 5'd15, 32'h1038);
		// x16 is the base of the store and load pair, eight bytes below the target word
		add_entry(encode_i(12'(STORE_ADDR - 8), 5'd0, F3_ADD, 5'd16, OPC_OP_IMM), 32'h3c, 32'h40,
			1'b1, 5'd16, `RV_XLEN'(STORE_ADDR - 8));
		add_entry(encode_s(12'd8, 5'd14, 5'd16), 32'h40, 32'h44, 1'b0, 5'd0, 32'h0);
		add_entry(encode_i(12'd8, 5'd16, F3_WORD, 5'd17, OPC_LOAD), 32'h44, 32'h48, 1'b1, 5'd17,
			32'h1234_5000);
		// each branch once taken and once not taken
		// x3 holds 2
		add_entry(encode_b(13'd8, 5'd1, 5'd1, BR_BEQ), 32'h48, 32'h50, 1'b0, 5'd0, 32'h0);
		add_entry(encode_b(13'd8, 5'd3, 5'd1, BR_BEQ), 32'h50, 32'h54, 1'b0, 5'd0, 32'h0);
		add_entry(encode_b(13'd8, 5'd3, 5'd1, BR_BNE), 32'h54, 32'h5c, 1'b0, 5'd0, 32'h0);
		add_entry(encode_b(13'd8, 5'd1, 5'd1, BR_BNE), 32'h5c, 32'h60, 1'b0, 5'd0, 32'h0);
		add_entry(encode_b(13'd8, 5'd1, 5'd2, BR_BLT), 32'h60, 32'h68, 1'b0, 5'd0, 32'h0);
		add_entry(encode_b(13'd8, 5'd2, 5'd1, BR_BLT), 32'h68, 32'h6c, 1'b0, 5'd0, 32'h0);
		add_entry(encode_b(13'd8, 5'd2, 5'd1, BR_BGE), 32'h6c, 32'h74, 1'b0, 5'd0, 32'h0);
		add_entry(encode_b(13'd8, 5'd1, 5'd2, BR_BGE), 32'h74, 32'h78, 1'b0, 5'd0, 32'h0);
		add_entry(encode_b(13'd8, 5'd2, 5'd1, BR_BLTU), 32'h78, 32'h80, 1'b0, 5'd0, 32'h0);
		add_entry(encode_b(13'd8, 5'd1, 5'd2, BR_BLTU), 32'h80, 32'h84, 1'b0, 5'd0, 32'h0);
		add_entry(encode_b(13'd8, 5'd1, 5'd2, BR_BGEU), 32'h84, 32'h8c, 1'b0, 5'd0, 32'h0);
		add_entry(encode_b(13'd8, 5'd2, 5'd1, BR_BGEU), 32'h8c, 32'h90, 1'b0, 5'd0, 32'h0);
		// backward branch by 16 bytes
		add_entry(encode_b(13'h1ff0, 5'd0, 5'd0, BR_BEQ), 32'h90, 32'h80, 1'b0, 5'd0, 32'h0);
		add_entry(encode_j(21'd16, 5'd18), 32'h80, 32'h90, 1'b1, 5'd18, 32'h84);
		// x16 + 5 is 0x45 and bit 0 is cleared
		add_entry(encode_i(12'd5, 5'd16, 3'b000, 5'd19, OPC_JALR), 32'h90, 32'h44, 1'b1, 5'd19,
			32'h94);
		add_entry(encode_j(21'h20, 5'd0), 32'h44, 32'h64, 1'b1, 5'd0, 32'h48);
		// x0 must still read zero after the link write above
		add_entry(encode_r(7'h00, 5'd1, 5'd0, F3_ADD, 5'd20), 32'h64, 32'h68, 1'b1, 5'd20, 32'h5);
	endtask

	// trace registers are sampled at the falling edge
	task automatic wait_retire(input int idx);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (!retire_valid && cycles < RETIRE_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		if (!retire_valid)
			fail_run($sformatf("entry %0d did not retire within %0d cycles",
				idx, RETIRE_TIMEOUT));
	endtask

	task automatic check_retire(input int idx);
		entry_t e;
		e = stim[idx];
		check_value($sformatf("entry %0d retire_pc", idx), retire_pc, e.pc);
		check_value($sformatf("entry %0d retire_next_pc", idx), retire_next_pc, e.next_pc);
		check_value($sformatf("entry %0d pc", idx), pc, e.next_pc);
		check_value($sformatf("entry %0d retire_rd_we", idx),
			`RV_XLEN'(retire_rd_we), `RV_XLEN'(e.rd_we));
		// rd and its data only mean something on a register write
		if (e.rd_we)
		begin
			check_value($sformatf("entry %0d retire_rd", idx),
				`RV_XLEN'(retire_rd), `RV_XLEN'(e.rd));
			check_value($sformatf("entry %0d retire_rd_data", idx), retire_rd_data, e.rd_data);
		end
	endtask

	// hard bound on the whole run
	initial
	begin
		#(CLK_PERIOD * RUN_LIMIT);
		fail_run("simulation ran past its cycle limit");
	end

	initial
	begin
		rst = 1'b1;
		instr_valid = 1'b0;
		instruction = 32'h0;
		build_table();
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		// no retire and no pc change in the idle cycles before the first strobe
		repeat (3)
		begin
			@(negedge clk);
			check_value("pc after reset", pc, `RV_XLEN'(0));
			check_value("retire_valid before first strobe", `RV_XLEN'(retire_valid),
				`RV_XLEN'(0));
		end
		for (int i = 0; i < stim.size(); i++)
		begin
			@(posedge clk);
			instr_valid <= 1'b1;
			instruction <= stim[i].instr;
			@(posedge clk);
			instr_valid <= 1'b0;
			instruction <= 32'h0;
			wait_retire(i);
			check_retire(i);
			// a one cycle strobe gives a one cycle retire
			@(negedge clk);
			check_value($sformatf("entry %0d retire_valid one cycle later", i),
				`RV_XLEN'(retire_valid), `RV_XLEN'(0));
		end
		$display("Simulation passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- rv_core.f
+incdir+common
common/rv_isa_pkg.sv
common/rv_ctrl_pkg.sv
decode/immediate_decode.sv
rtl/reg_file.sv
rtl/alu.sv
rtl/data_mem.sv
rtl/rv_core.sv
dv/rv_core_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile the rv_core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --assert -sv --top-module rv_core_tb -f rv_core.f -o rv_core_sim

out=$(./obj_dir/rv_core_sim 2>&1) || true
printf '%s\n' "$out"

# the run passed only if the testbench printed its pass line
if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
	exit 0
else
	exit 1
fi
